//--- Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the RV32I core testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f vlog.f --top-module rv_core_tb -Mdir obj_dir -o rv_core_sim
	@out="$$(./obj_dir/rv_core_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

//--- design/rv_alu.sv
`default_nettype none

`include "rv_params.svh"

module rv_alu import rv_pkg::*; (
    input  instr_t            instr,
    input  logic              is_arith_r,
    input  logic              is_arith_i,
    input  logic              is_branch,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic [`XLEN-1:0]  imm_i,
    output logic [`XLEN-1:0]  alu_result,
    output logic              branch_taken
);

    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] sum;
    logic [`XLEN-1:0] diff;
    logic             carry;
    logic             zero;
    logic             ovf;
    logic             sign;
    logic             lt_signed;
    logic [4:0]       shamt;
    logic             alt;

    // Branches compare two registers, I-type uses the immediate
    assign op_b = is_arith_i ? imm_i : rs2_data;

    assign sum = rs1_data + op_b;

    // Carry here is the borrow, set when rs1 is below op_b unsigned
    assign {carry, diff} = {1'b0, rs1_data} - {1'b0, op_b};
    assign zero = (diff == '0);
    assign ovf = (rs1_data[`XLEN-1] != op_b[`XLEN-1]) && (diff[`XLEN-1] != rs1_data[`XLEN-1]);
    assign sign = diff[`XLEN-1];
    assign lt_signed = sign ^ ovf;

    // Immediate shifts find the shamt field in the low immediate bits
    assign shamt = op_b[4:0];
    assign alt = (instr.r_fmt.funct7 == `F7_ALT);

    always_comb begin
        case (instr.r_fmt.funct3)
            `F3_ADDSUB: alu_result = (is_arith_r && alt) ? diff : sum;
            `F3_SLL:    alu_result = rs1_data << shamt;
            `F3_SLT:    alu_result = {{(`XLEN-1){1'b0}}, lt_signed};
            `F3_SLTU:   alu_result = {{(`XLEN-1){1'b0}}, carry};
            `F3_XOR:    alu_result = rs1_data ^ op_b;
            `F3_SRL_SRA: begin
                if (alt) begin
                    alu_result = $unsigned($signed(rs1_data) >>> shamt);
                end else begin
                    alu_result = rs1_data >> shamt;
                end
            end
            `F3_OR:     alu_result = rs1_data | op_b;
            default:    alu_result = rs1_data & op_b;
        endcase
    end

    // Branch condition straight from the subtract flags
    always_comb begin
        case (instr.b_fmt.funct3)
            `F3_BEQ:  branch_taken = is_branch && zero;
            `F3_BNE:  branch_taken = is_branch && !zero;
            `F3_BLT:  branch_taken = is_branch && lt_signed;
            `F3_BGE:  branch_taken = is_branch && !lt_signed;
            `F3_BLTU: branch_taken = is_branch && carry;
            `F3_BGEU: branch_taken = is_branch && !carry;
            default:  branch_taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/rv_control.sv
`default_nettype none

`include "rv_params.svh"

module rv_control import rv_pkg::*; (
    input  logic              clk_in,
    input  logic              reset_in,
    input  logic              mem_busy,
    input  logic [`XLEN-1:0]  mem_rdata,
    input  logic [`XLEN-1:0]  data_addr,
    input  logic [`XLEN-1:0]  alu_result,
    input  logic [`XLEN-1:0]  load_data,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  imm_i,
    input  logic [`XLEN-1:0]  imm_b,
    input  logic [`XLEN-1:0]  imm_u,
    input  logic [`XLEN-1:0]  imm_j,
    input  logic              is_arith_r,
    input  logic              is_arith_i,
    input  logic              is_branch,
    input  logic              is_jal,
    input  logic              is_jalr,
    input  logic              is_load,
    input  logic              is_store,
    input  logic              is_lui,
    input  logic              is_auipc,
    input  logic              branch_taken,
    output instr_t            instr,
    output logic              capture,
    output logic              wb_en,
    output logic [`XLEN-1:0]  wb_data,
    output logic [1:0]        mem_cmd,
    output logic [`XLEN-1:0]  mem_addr
);

    logic [3:0]       state;
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] pc_next;
    logic             run;

    assign pc_plus4 = pc + 32'd4;

    // First fetch is issued once reset has been sampled high
    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            state <= `ST_FETCH;
            pc <= `RESET_PC;
            instr <= '0;
            run <= 1'b0;
        end else begin
            run <= 1'b1;
            case (state)
                `ST_FETCH: begin
                    if (run) begin
                        state <= `ST_WAIT_FETCH;
                    end
                end
                `ST_WAIT_FETCH: begin
                    if (!mem_busy) begin
                        instr <= mem_rdata;
                        state <= `ST_EXECUTE;
                    end
                end
                `ST_EXECUTE: begin
                    pc <= pc_next;
                    state <= (is_load || is_store) ? `ST_WAIT_MEM : `ST_FETCH;
                end
                default: begin
                    if (!mem_busy) begin
                        state <= `ST_FETCH;
                    end
                end
            endcase
        end
    end

    always_comb begin
        pc_next = pc_plus4;
        if (is_jal) begin
            pc_next = pc + imm_j;
        end else if (is_jalr) begin
            pc_next = (rs1_data + imm_i) & ~32'd1;
        end else if (is_branch && branch_taken) begin
            pc_next = pc + imm_b;
        end
    end

    // Operands are captured in the same cycle the instruction is latched
    assign capture = (state == `ST_WAIT_FETCH) && !mem_busy;

    assign wb_en = ((state == `ST_EXECUTE) &&
                    (is_arith_r || is_arith_i || is_lui || is_auipc || is_jal || is_jalr)) ||
                   ((state == `ST_WAIT_MEM) && is_load && !mem_busy);

    always_comb begin
        wb_data = alu_result;
        if (is_lui) begin
            wb_data = imm_u;
        end else if (is_auipc) begin
            wb_data = pc + imm_u;
        end else if (is_jal || is_jalr) begin
            wb_data = pc_plus4;
        end else if (is_load) begin
            wb_data = load_data;
        end
    end

    always_comb begin
        mem_cmd = `MEM_CMD_NONE;
        if ((state == `ST_FETCH) && run) begin
            mem_cmd = `MEM_CMD_LOAD;
        end else if (state == `ST_EXECUTE) begin
            if (is_load) begin
                mem_cmd = `MEM_CMD_LOAD;
            end else if (is_store) begin
                mem_cmd = `MEM_CMD_STORE;
            end
        end
    end

    // Data address is held through WAIT_MEM since instr and operands stay put
    assign mem_addr = ((state == `ST_FETCH) || (state == `ST_WAIT_FETCH)) ? pc : data_addr;

    a_cmd_pulse: assert property (
        @(posedge clk_in) disable iff (!reset_in)
        (mem_cmd != `MEM_CMD_NONE) |->
            ((state == `ST_FETCH) || (state == `ST_EXECUTE))
            ##1 ((state == `ST_WAIT_FETCH) || (state == `ST_WAIT_MEM))
    ) else $error("memory command outside FETCH or EXECUTE");

endmodule

`default_nettype wire

//--- design/rv_core.sv
`default_nettype none

`include "rv_params.svh"

module rv_core import rv_pkg::*; (
    input  logic              clk_in,
    input  logic              reset_in,
    input  logic              mem_busy,
    input  logic [`XLEN-1:0]  mem_rdata,
    output logic [1:0]        mem_cmd,
    output logic [`XLEN-1:0]  mem_addr,
    output logic [`XLEN-1:0]  mem_wdata,
    output logic [3:0]        mem_wmask
);

    instr_t           instr;
    logic             is_arith_r;
    logic             is_arith_i;
    logic             is_branch;
    logic             is_jal;
    logic             is_jalr;
    logic             is_load;
    logic             is_store;
    logic             is_lui;
    logic             is_auipc;
    logic [`XLEN-1:0] imm_i;
    logic [`XLEN-1:0] imm_s;
    logic [`XLEN-1:0] imm_b;
    logic [`XLEN-1:0] imm_u;
    logic [`XLEN-1:0] imm_j;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_result;
    logic             branch_taken;
    logic [`XLEN-1:0] data_addr;
    logic [`XLEN-1:0] load_data;
    logic             capture;
    logic             wb_en;
    logic [`XLEN-1:0] wb_data;

    rv_decoder i_decoder (.*);

    // Source fields come from the word on the bus as the fetch completes
    rv_regfile i_regfile (
        .capture_word (mem_rdata),
        .wb_rd        (instr.r_fmt.rd),
        .*
    );

    rv_alu i_alu (.*);

    // LSU address goes to control, which muxes it with the pc
    rv_lsu i_lsu (
        .mem_addr    (data_addr),
        .byte_offset (),
        .*
    );

    rv_control i_control (.*);

endmodule

`default_nettype wire

//--- design/rv_decoder.sv
`default_nettype none

`include "rv_params.svh"

module rv_decoder import rv_pkg::*; (
    input  instr_t            instr,
    output logic              is_arith_r,
    output logic              is_arith_i,
    output logic              is_branch,
    output logic              is_jal,
    output logic              is_jalr,
    output logic              is_load,
    output logic              is_store,
    output logic              is_lui,
    output logic              is_auipc,
    output logic [`XLEN-1:0]  imm_i,
    output logic [`XLEN-1:0]  imm_s,
    output logic [`XLEN-1:0]  imm_b,
    output logic [`XLEN-1:0]  imm_u,
    output logic [`XLEN-1:0]  imm_j
);

    logic [6:0] opcode;

    assign opcode = instr.r_fmt.opcode;

    // SYSTEM and unknown opcodes raise no flag and fall through as no-ops
    assign is_arith_r = (opcode == `OPC_ARITH_R);
    assign is_arith_i = (opcode == `OPC_ARITH_I);
    assign is_branch  = (opcode == `OPC_BRANCH);
    assign is_jal     = (opcode == `OPC_JAL);
    assign is_jalr    = (opcode == `OPC_JALR);
    assign is_load    = (opcode == `OPC_LOAD);
    assign is_store   = (opcode == `OPC_STORE);
    assign is_lui     = (opcode == `OPC_LUI);
    assign is_auipc   = (opcode == `OPC_AUIPC);

    // Sign-extended immediates, each from its own format view
    assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign imm_u = {instr.u_fmt.imm, 12'h000};

    assign imm_b = {{19{instr.b_fmt.imm_12}},
                    instr.b_fmt.imm_12,
                    instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5,
                    instr.b_fmt.imm_4_1,
                    1'b0};

    assign imm_j = {{11{instr.j_fmt.imm_20}},
                    instr.j_fmt.imm_20,
                    instr.j_fmt.imm_19_12,
                    instr.j_fmt.imm_11,
                    instr.j_fmt.imm_10_1,
                    1'b0};

endmodule

`default_nettype wire

//--- design/rv_lsu.sv
`default_nettype none

`include "rv_params.svh"

module rv_lsu import rv_pkg::*; (
    input  instr_t            instr,
    input  logic              is_load,
    input  logic              is_store,
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic [`XLEN-1:0]  imm_i,
    input  logic [`XLEN-1:0]  imm_s,
    input  logic [`XLEN-1:0]  mem_rdata,
    output logic [`XLEN-1:0]  mem_addr,
    output logic [1:0]        byte_offset,
    output logic [`XLEN-1:0]  mem_wdata,
    output logic [3:0]        mem_wmask,
    output logic [`XLEN-1:0]  load_data
);

    logic [`XLEN-1:0] eff_addr;
    logic [1:0]       size;
    logic             is_unsigned;
    logic [4:0]       lane_shift;
    logic [`XLEN-1:0] rdata_lane;

    assign eff_addr = rs1_data + (is_store ? imm_s : imm_i);
    assign mem_addr = {eff_addr[`XLEN-1:2], 2'b00};
    assign byte_offset = eff_addr[1:0];

    assign size = instr.i_fmt.funct3[1:0];
    assign is_unsigned = instr.i_fmt.funct3[2];
    assign lane_shift = {byte_offset, 3'b000};

    // Store data moves into the lane of its address, mask bit 0 is the lowest byte
    always_comb begin
        if (is_load) begin
            mem_wmask = 4'b1111;
            mem_wdata = rs2_data;
        end else begin
            case (size)
                `F3_MEM_BYTE: begin
                    mem_wmask = 4'b0001 << byte_offset;
                    mem_wdata = {24'h0, rs2_data[7:0]} << lane_shift;
                end
                `F3_MEM_HALF: begin
                    mem_wmask = 4'b0011 << byte_offset;
                    mem_wdata = {16'h0, rs2_data[15:0]} << lane_shift;
                end
                default: begin
                    mem_wmask = 4'b1111;
                    mem_wdata = rs2_data;
                end
            endcase
        end
    end

    // Loaded byte or half is brought down to bit 0 and then extended
    assign rdata_lane = mem_rdata >> lane_shift;

    always_comb begin
        case (size)
            `F3_MEM_BYTE: load_data = {{24{!is_unsigned && rdata_lane[7]}}, rdata_lane[7:0]};
            `F3_MEM_HALF: load_data = {{16{!is_unsigned && rdata_lane[15]}}, rdata_lane[15:0]};
            default:      load_data = mem_rdata;
        endcase
    end

    always_comb begin
        if (is_load || is_store) begin
            a_aligned: assert final (
                !((size == `F3_MEM_HALF) && byte_offset[0]) &&
                !((size == `F3_MEM_WORD) && (byte_offset != 2'b00))
            ) else $error("misaligned access at %h", eff_addr);
        end
    end

endmodule

`default_nettype wire

//--- design/rv_params.svh
`ifndef RV_PARAMS_SVH
`define RV_PARAMS_SVH

// Datapath and register file sizes
`define XLEN        32
`define REG_COUNT   32
`define REG_AW      5
`define RESET_PC    32'h0000_0000

// Major opcodes
`define OPC_ARITH_R 7'b0110011
`define OPC_ARITH_I 7'b0010011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_JALR    7'b1100111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_LUI     7'b0110111
`define OPC_AUIPC   7'b0010111

// Arithmetic funct3
`define F3_ADDSUB   3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL_SRA  3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// Branch funct3
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// Access size, funct3 bit 2 marks an unsigned load
`define F3_MEM_BYTE 2'b00
`define F3_MEM_HALF 2'b01
`define F3_MEM_WORD 2'b10

// Selects sub and arithmetic shift right
`define F7_ALT      7'b0100000

// One-hot control states
`define ST_FETCH      4'b0001
`define ST_WAIT_FETCH 4'b0010
`define ST_EXECUTE    4'b0100
`define ST_WAIT_MEM   4'b1000

// Memory port commands
`define MEM_CMD_NONE  2'd0
`define MEM_CMD_LOAD  2'd1
`define MEM_CMD_STORE 2'd2

`endif

//--- design/rv_pkg.sv
`default_nettype none

`include "rv_params.svh"

package rv_pkg;

    // One instruction word, read in each of the RV32I encodings
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        // Branch offset bits are scattered across the word
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j_fmt;
        logic [`XLEN-1:0] raw;
    } instr_t;

endpackage

`default_nettype wire

//--- design/rv_regfile.sv
`default_nettype none

`include "rv_params.svh"

module rv_regfile import rv_pkg::*; (
    input  logic               clk_in,
    input  logic               reset_in,
    input  logic               capture,
    input  instr_t             capture_word,
    input  logic               wb_en,
    input  logic [`REG_AW-1:0] wb_rd,
    input  logic [`XLEN-1:0]   wb_data,
    output logic [`XLEN-1:0]   rs1_data,
    output logic [`XLEN-1:0]   rs2_data
);

    logic [`XLEN-1:0] regs [`REG_COUNT];

    // x0 stays zero since writes to it are dropped
    always_ff @(posedge clk_in) begin
        if (!reset_in) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && (wb_rd != '0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // Operands are read from the word arriving on the bus, before it is latched
    always_ff @(posedge clk_in) begin
        if (capture) begin
            rs1_data <= regs[capture_word.r_fmt.rs1];
            rs2_data <= regs[capture_word.r_fmt.rs2];
        end
    end

    a_x0_reads_zero: assert property (
        @(posedge clk_in) disable iff (!reset_in)
        (capture && (capture_word.r_fmt.rs1 == '0)) |=> (rs1_data == '0)
    ) else $error("rs1_data nonzero after capture of x0");

endmodule

`default_nettype wire

//--- verif/rv_core_stimulus.txt
# P addr w0 w1 w2 w3 : four program words from addr / D addr word : initial data word
# S addr mask data : expected store in program order, mask bit 0 is the lowest byte
P 00000000 00700093 FFD00113 402081B3 10000513
P 00000010 00352023 00112233 001132B3 00452223
P 00000020 00552423 40115313 001093B3 00652623
P 00000030 00752823 00108463 00052023 00109463
P 00000040 0080046F 00052023 123454B7 00001597
P 00000050 00852A23 00952C23 00B52E23 04150603
P 00000060 04354683 04251703 04055783 02C52023
P 00000070 02D52223 02E52423 02F52623 02C50823
P 00000080 02C508A3 02C50923 02C509A3 02E51A23
P 00000090 02E51B23 09C00867 00052023 03052C23
P 000000A0 00114463 00052023 0000006F 0000006F
D 00000140 80F182F3
S 00000100 F 0000000A
S 00000104 F 00000001
S 00000108 F 00000000
S 0000010C F FFFFFFFE
S 00000110 F 00000380
S 00000114 F 00000044
S 00000118 F 12345000
S 0000011C F 0000104C
S 00000120 F FFFFFF82
S 00000124 F 00000080
S 00000128 F FFFF80F1
S 0000012C F 000082F3
S 00000130 1 00000082
S 00000130 2 00008200
S 00000130 4 00820000
S 00000130 8 82000000
S 00000134 3 000080F1
S 00000134 C 80F10000
S 00000138 F 00000098

//--- verif/rv_core_tb.sv
`default_nettype none

`include "rv_params.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int MEM_WORDS = 256;
    localparam int RUN_LIMIT = 5000;

    logic             clk_in = 1'b0;
    logic             reset_in = 1'b0;
    logic             mem_busy = 1'b0;
    logic [`XLEN-1:0] mem_rdata = '0;
    logic [1:0]       mem_cmd;
    logic [`XLEN-1:0] mem_addr;
    logic [`XLEN-1:0] mem_wdata;
    logic [3:0]       mem_wmask;

    logic [`XLEN-1:0] mem [MEM_WORDS];
    logic [`XLEN-1:0] exp_addr [$];
    logic [3:0]       exp_mask [$];
    logic [`XLEN-1:0] exp_data [$];

    int               error_count = 0;
    int               fetch_count = 0;
    int               store_count = 0;
    int               halt_fetches = 0;
    int               remaining = 0;
    int               cycles = 0;
    bit               timed_out = 1'b0;
    logic [1:0]       act_cmd = '0;
    logic [`XLEN-1:0] act_addr = '0;
    logic [`XLEN-1:0] act_wdata = '0;
    logic [3:0]       act_wmask = '0;
    bit               act_is_data = 1'b0;
    bit               data_pending = 1'b0;
    bit               have_prev = 1'b0;
    logic [`XLEN-1:0] prev_pc = '0;
    instr_t           prev_instr = '0;

    always #20 clk_in = ~clk_in;

    rv_core i_dut (
        .clk_in    (clk_in),
        .reset_in  (reset_in),
        .mem_busy  (mem_busy),
        .mem_rdata (mem_rdata),
        .mem_cmd   (mem_cmd),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_wmask (mem_wmask)
    );

    task automatic report_mismatch(input string msg);
        $display("MISMATCH at %0t: %s", $time, msg);
        error_count++;
    endtask

    // Next fetch follows from the previous instruction by the RV32I rules
    task automatic check_fetch(input logic [`XLEN-1:0] addr, input instr_t word);
        logic [`XLEN-1:0] w;
        logic [`XLEN-1:0] b_off;
        logic [`XLEN-1:0] j_off;
        w = prev_instr.raw;
        b_off = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        j_off = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        if (!have_prev) begin
            if (addr !== `RESET_PC) begin
                report_mismatch($sformatf("first fetch at %h, expected reset pc", addr));
            end
        end else begin
            case (prev_instr.r_fmt.opcode)
                `OPC_JAL: begin
                    if (addr !== prev_pc + j_off) begin
                        report_mismatch($sformatf("fetch %h after JAL at %h", addr, prev_pc));
                    end
                end
                `OPC_BRANCH: begin
                    if ((addr !== prev_pc + 32'd4) && (addr !== prev_pc + b_off)) begin
                        report_mismatch($sformatf("fetch %h after branch at %h", addr, prev_pc));
                    end
                end
                // Target depends on a register value
                `OPC_JALR: begin
                end
                default: begin
                    if (addr !== prev_pc + 32'd4) begin
                        report_mismatch($sformatf("fetch %h, expected %h", addr, prev_pc + 32'd4));
                    end
                end
            endcase
        end
        have_prev = 1'b1;
        prev_pc = addr;
        prev_instr = word;
        fetch_count++;
        if (word.raw == 32'h0000_006f) begin
            halt_fetches++;
        end
        data_pending = (word.r_fmt.opcode == `OPC_LOAD) || (word.r_fmt.opcode == `OPC_STORE);
    endtask

    task automatic check_store(input logic [`XLEN-1:0] addr, input logic [3:0] mask,
                               input logic [`XLEN-1:0] data);
        logic [`XLEN-1:0] e_addr;
        logic [3:0]       e_mask;
        logic [`XLEN-1:0] e_data;
        store_count++;
        if (exp_addr.size() == 0) begin
            $display("Unexpected extra store to %h at time %0t", addr, $time);
            error_count++;
        end else begin
            e_addr = exp_addr.pop_front();
            e_mask = exp_mask.pop_front();
            e_data = exp_data.pop_front();
            if ((addr !== e_addr) || (mask !== e_mask) || (data !== e_data)) begin
                report_mismatch($sformatf("store %h/%h/%h, expected %h/%h/%h",
                                          addr, mask, data, e_addr, e_mask, e_data));
            end
        end
    endtask

    task automatic load_stimulus();
        int               fd;
        int               idx;
        string            line;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] w0;
        logic [`XLEN-1:0] w1;
        logic [`XLEN-1:0] w2;
        logic [`XLEN-1:0] w3;
        logic [3:0]       m;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'h5a00_0000 | (32'(i) << 2);
        end
        fd = $fopen("verif/rv_core_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Cannot open stimulus file verif/rv_core_stimulus.txt");
            error_count++;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(line, fd) > 0) begin
                    if (line[0] == "P" &&
                        $sscanf(line, "P %h %h %h %h %h", a, w0, w1, w2, w3) == 5) begin
                        idx = int'(a[9:2]);
                        mem[idx] = w0;
                        mem[idx + 1] = w1;
                        mem[idx + 2] = w2;
                        mem[idx + 3] = w3;
                    end else if (line[0] == "D" && $sscanf(line, "D %h %h", a, w0) == 2) begin
                        mem[int'(a[9:2])] = w0;
                    end else if (line[0] == "S" &&
                                 $sscanf(line, "S %h %h %h", a, m, w0) == 3) begin
                        exp_addr.push_back(a);
                        exp_mask.push_back(m);
                        exp_data.push_back(w0);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Memory answers on the falling edge, busy for 1 to 4 wait cycles
    always @(negedge clk_in) begin
        int idx;
        if (!reset_in) begin
            mem_busy = 1'b0;
            if (mem_cmd !== `MEM_CMD_NONE) begin
                $display("Memory command issued during reset at time %0t", $time);
                error_count++;
            end
        end else if (mem_busy) begin
            if (mem_addr !== act_addr) begin
                report_mismatch($sformatf("address moved to %h while busy", mem_addr));
            end
            if ((act_cmd == `MEM_CMD_STORE) &&
                ((mem_wdata !== act_wdata) || (mem_wmask !== act_wmask))) begin
                report_mismatch("store data or mask changed while busy");
            end
            if (remaining > 0) begin
                remaining--;
            end else begin
                idx = int'(act_addr[9:2]);
                if (act_addr >= 4 * MEM_WORDS) begin
                    $display("Access to %h is outside the memory model", act_addr);
                    error_count++;
                end else if (act_cmd == `MEM_CMD_STORE) begin
                    for (int b = 0; b < 4; b++) begin
                        if (act_wmask[b]) begin
                            mem[idx][8*b +: 8] = act_wdata[8*b +: 8];
                        end
                    end
                end else begin
                    mem_rdata = mem[idx];
                    if (!act_is_data) begin
                        check_fetch(act_addr, mem[idx]);
                    end
                end
                mem_busy = 1'b0;
            end
        end else if (mem_cmd !== `MEM_CMD_NONE) begin
            act_cmd = mem_cmd;
            act_addr = mem_addr;
            act_wdata = mem_wdata;
            act_wmask = mem_wmask;
            act_is_data = data_pending;
            data_pending = 1'b0;
            if (mem_addr[1:0] !== 2'b00) begin
                report_mismatch($sformatf("unaligned memory address %h", mem_addr));
            end
            if (!act_is_data && (mem_cmd !== `MEM_CMD_LOAD)) begin
                report_mismatch("instruction fetch is not a LOAD command");
            end
            if (mem_cmd == `MEM_CMD_STORE) begin
                check_store(mem_addr, mem_wmask, mem_wdata);
            end
            remaining = int'($urandom % 4) + 1;
            mem_busy = 1'b1;
        end
    end

    initial begin
        void'($urandom(15979));
        load_stimulus();
        repeat (16) @(negedge clk_in);
        reset_in = 1'b1;
        while (((exp_addr.size() != 0) || (halt_fetches < 2)) && (cycles < RUN_LIMIT)) begin
            @(posedge clk_in);
            cycles++;
        end
        if ((exp_addr.size() != 0) || (halt_fetches < 2)) begin
            $display("Timeout: stores or final self-jump not seen within %0d cycles", RUN_LIMIT);
            timed_out = 1'b1;
        end
        $display("Summary: %0d errors, %0d fetches, %0d stores, %0d stores missing",
                 error_count, fetch_count, store_count, exp_addr.size());
        if ((error_count == 0) && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+design
design/rv_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_lsu.sv
design/rv_control.sv
design/rv_core.sv
verif/rv_core_tb.sv
